// File: source/exec_pkg.sv
`default_nettype none

package exec_pkg;

	typedef enum logic [2:0] {
		FMT_R = 3'd0,
		FMT_I = 3'd1,
		FMT_S = 3'd2,
		FMT_B = 3'd3,
		FMT_U = 3'd4,
		FMT_J = 3'd5
	} insn_fmt_t;

	// rv32i major opcodes handled here
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_XOR   = 4'd3,
		ALU_OR    = 4'd4,
		ALU_SRL   = 4'd5,
		ALU_SRA   = 4'd6,
		ALU_SLL   = 4'd7,
		ALU_LESS  = 4'd8,
		ALU_ULESS = 4'd9
	} alu_op_t;

	localparam logic [11:0] CSR_MSTATUS = 12'h300;
	localparam logic [11:0] CSR_MTVEC   = 12'h305;
	localparam logic [11:0] CSR_MEPC    = 12'h341;
	localparam logic [11:0] CSR_MCAUSE  = 12'h342;

	typedef struct packed {
		logic [6:0]  opcode;
		insn_fmt_t   fmt;
		logic [2:0]  funct3;
		logic [6:0]  funct7;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] csr_addr;
		logic [31:0] imm;      // sign extended
	} decoded_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic [4:0]  rd;
		logic [31:0] rd_wdata;
		logic        rd_we;
		logic        is_store;
		logic [31:0] st_addr;
		logic [31:0] st_data;
		logic [3:0]  st_mask;
	} commit_t;

endpackage

`default_nettype wire

// File: source/exec_if.sv
`timescale 1ns/100ps
`default_nettype none

// decoded instruction, accept side to execute side
interface issue_if;

	logic                valid;
	exec_pkg::decoded_t  dec;
	logic                take;  // one cycle, consumes dec

	modport src (
		output valid,
		output dec,
		input  take
	);

	modport dst (
		input  valid,
		input  dec,
		output take
	);

endinterface

// one commit record into the output slot
interface commit_if;

	logic                full;
	logic                load;  // one cycle
	exec_pkg::commit_t   rec;

	modport src (
		input  full,
		output load,
		output rec
	);

	modport dst (
		output full,
		input  load,
		input  rec
	);

endinterface

`default_nettype wire

// File: source/insn_accept.sv
`timescale 1ns/100ps
`default_nettype none

module insn_accept (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_req,
	output logic        in_ack,
	input  logic [31:0] in_insn,
	issue_if.src        iss
);

	typedef enum logic {RX_IDLE, RX_ACK} rx_state_t;

	rx_state_t           rx_state;
	logic                capt;     // word latched, ack next
	logic                pending;
	logic                accept;
	logic [31:0]         insn_q;
	exec_pkg::insn_fmt_t fmt;
	logic [31:0]         imm;
	exec_pkg::decoded_t  dec;

	// only while ack is low and the slot is free
	assign accept = in_req & (rx_state == RX_IDLE) & ~capt & ~pending;

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_state <= RX_IDLE;
			capt <= 1'b0;
			pending <= 1'b0;
		end else begin
			capt <= accept;
			case (rx_state)
				RX_IDLE: if (capt) rx_state <= RX_ACK;
				RX_ACK:  if (!in_req) rx_state <= RX_IDLE;
				default: rx_state <= RX_IDLE;
			endcase
			if (capt)
				pending <= 1'b1;
			else if (iss.take)
				pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			insn_q <= in_insn;
	end

	always_comb begin
		case (insn_q[6:0])
			exec_pkg::OPC_LUI, exec_pkg::OPC_AUIPC: fmt = exec_pkg::FMT_U;
			exec_pkg::OPC_JAL:    fmt = exec_pkg::FMT_J;
			exec_pkg::OPC_BRANCH: fmt = exec_pkg::FMT_B;
			exec_pkg::OPC_STORE:  fmt = exec_pkg::FMT_S;
			exec_pkg::OPC_JALR, exec_pkg::OPC_OPIMM, exec_pkg::OPC_SYSTEM: fmt = exec_pkg::FMT_I;
			default:              fmt = exec_pkg::FMT_R;
		endcase
		case (fmt)
			exec_pkg::FMT_I: imm = {{20{insn_q[31]}}, insn_q[31:20]};
			exec_pkg::FMT_S: imm = {{20{insn_q[31]}}, insn_q[31:25], insn_q[11:7]};
			exec_pkg::FMT_B: imm = {{19{insn_q[31]}}, insn_q[31], insn_q[7],
				insn_q[30:25], insn_q[11:8], 1'b0};
			exec_pkg::FMT_U: imm = {insn_q[31:12], 12'b0};
			exec_pkg::FMT_J: imm = {{11{insn_q[31]}}, insn_q[31], insn_q[19:12],
				insn_q[20], insn_q[30:21], 1'b0};
			default:         imm = 32'b0;  // R type
		endcase
	end

	always_comb begin
		dec.opcode = insn_q[6:0];
		dec.fmt = fmt;
		dec.funct3 = insn_q[14:12];
		dec.funct7 = insn_q[31:25];
		dec.rd = insn_q[11:7];
		dec.rs1 = insn_q[19:15];
		dec.rs2 = insn_q[24:20];
		dec.csr_addr = insn_q[31:20];
		dec.imm = imm;
	end

	assign in_ack = (rx_state == RX_ACK);
	assign iss.valid = pending;
	assign iss.dec = dec;

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	output logic [31:0] rs1_data,
	output logic [31:0] rs2_data,
	input  logic [4:0]  rd,
	input  logic        rd_we,
	input  logic [31:0] rd_wdata,
	input  logic [11:0] csr_addr,
	output logic [31:0] csr_rdata,
	input  logic        csr_we,
	input  logic [31:0] csr_wdata
);

	logic [31:0] gpr [1:31];  // x0 not stored
	logic [31:0] mstatus;
	logic [31:0] mtvec;
	logic [31:0] mepc;
	logic [31:0] mcause;

	assign rs1_data = (rs1 == 5'd0) ? 32'b0 : gpr[rs1];
	assign rs2_data = (rs2 == 5'd0) ? 32'b0 : gpr[rs2];

	always_ff @(posedge clk) begin
		if (rd_we && rd != 5'd0)
			gpr[rd] <= rd_wdata;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mstatus <= 32'b0;
			mtvec <= 32'b0;
			mepc <= 32'b0;
			mcause <= 32'b0;
		end else if (csr_we) begin
			case (csr_addr)
				exec_pkg::CSR_MSTATUS: mstatus <= csr_wdata;
				exec_pkg::CSR_MTVEC:   mtvec <= csr_wdata;
				exec_pkg::CSR_MEPC:    mepc <= csr_wdata;
				exec_pkg::CSR_MCAUSE:  mcause <= csr_wdata;
				default: ;  // unknown csr, write dropped
			endcase
		end
	end

	always_comb begin
		case (csr_addr)
			exec_pkg::CSR_MSTATUS: csr_rdata = mstatus;
			exec_pkg::CSR_MTVEC:   csr_rdata = mtvec;
			exec_pkg::CSR_MEPC:    csr_rdata = mepc;
			exec_pkg::CSR_MCAUSE:  csr_rdata = mcause;
			default:               csr_rdata = 32'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/exu.sv
`timescale 1ns/100ps
`default_nettype none

module exu (
	input  logic [6:0]          opcode,
	input  logic [31:0]         src1,
	input  logic [31:0]         src2,
	input  logic [31:0]         imm,
	input  exec_pkg::insn_fmt_t fmt,
	input  logic [2:0]          funct3,
	input  logic [6:0]          funct7,
	input  logic [31:0]         pc,
	input  logic [31:0]         csr_val,
	output logic [31:0]         val,
	output logic [31:0]         jump,
	output logic [31:0]         csr_wdata,
	output logic [3:0]          wmask
);

	logic [31:0]       lop;
	logic [31:0]       rop;
	exec_pkg::alu_op_t op;
	logic [32:0]       op_diff;
	logic              op_less;
	logic [32:0]       br_diff;
	logic              br_less;
	logic              br_eq;
	logic              br_cond;
	logic              jump_en;
	logic [31:0]       jbase;

	always_comb begin
		case (opcode)
			exec_pkg::OPC_AUIPC, exec_pkg::OPC_JAL, exec_pkg::OPC_JALR: lop = pc;
			exec_pkg::OPC_OPIMM, exec_pkg::OPC_OP: lop = src1;
			default: lop = 32'b0;  // lui: 0 + imm
		endcase
		case (opcode)
			exec_pkg::OPC_LUI, exec_pkg::OPC_AUIPC, exec_pkg::OPC_OPIMM: rop = imm;
			exec_pkg::OPC_JAL, exec_pkg::OPC_JALR: rop = 32'd4;  // link value
			exec_pkg::OPC_OP: rop = src2;
			default: rop = 32'b0;
		endcase
	end

	// funct3 picks the operator only for R and I formats
	always_comb begin
		op = exec_pkg::ALU_ADD;
		if (fmt == exec_pkg::FMT_I || fmt == exec_pkg::FMT_R) begin
			case (funct3)
				3'b000: op = (fmt == exec_pkg::FMT_R && funct7[5]) ?
					exec_pkg::ALU_SUB : exec_pkg::ALU_ADD;
				3'b001: op = exec_pkg::ALU_SLL;
				3'b010: op = exec_pkg::ALU_LESS;
				3'b011: op = exec_pkg::ALU_ULESS;
				3'b100: op = exec_pkg::ALU_XOR;
				3'b101: op = funct7[5] ? exec_pkg::ALU_SRA : exec_pkg::ALU_SRL;
				3'b110: op = exec_pkg::ALU_OR;
				default: op = exec_pkg::ALU_AND;
			endcase
		end
	end

	assign op_diff = {1'b0, lop} - {1'b0, rop};  // bit 32 is the borrow
	assign op_less = (lop[31] != rop[31]) ? lop[31] : op_diff[31];

	always_comb begin
		case (op)
			exec_pkg::ALU_ADD:   val = lop + rop;
			exec_pkg::ALU_SUB:   val = op_diff[31:0];
			exec_pkg::ALU_AND:   val = lop & rop;
			exec_pkg::ALU_XOR:   val = lop ^ rop;
			exec_pkg::ALU_OR:    val = lop | rop;
			exec_pkg::ALU_SRL:   val = lop >> rop[4:0];
			exec_pkg::ALU_SRA:   val = $signed(lop) >>> rop[4:0];
			exec_pkg::ALU_SLL:   val = lop << rop[4:0];
			exec_pkg::ALU_LESS:  val = {31'b0, op_less};
			exec_pkg::ALU_ULESS: val = {31'b0, op_diff[32]};
			default:             val = 32'b0;
		endcase
	end

	// branch compare works on the raw register operands
	assign br_diff = {1'b0, src1} - {1'b0, src2};
	assign br_eq = (br_diff[31:0] == 32'b0);
	assign br_less = (src1[31] != src2[31]) ? src1[31] : br_diff[31];

	always_comb begin
		case (funct3)
			3'b000:  br_cond = br_eq;
			3'b001:  br_cond = ~br_eq;
			3'b100:  br_cond = br_less;
			3'b101:  br_cond = ~br_less;
			3'b110:  br_cond = br_diff[32];
			3'b111:  br_cond = ~br_diff[32];
			default: br_cond = 1'b0;
		endcase
	end

	assign jbase = (fmt == exec_pkg::FMT_I) ? src1 : pc;  // jalr base is rs1
	assign jump_en = (fmt == exec_pkg::FMT_J) | (opcode == exec_pkg::OPC_JALR) |
		((fmt == exec_pkg::FMT_B) & br_cond);
	assign jump = (jbase + imm) & {32{jump_en}};

	always_comb begin
		case (funct3[1:0])
			2'b00:   wmask = 4'h1;
			2'b01:   wmask = 4'h3;
			2'b10:   wmask = 4'hf;
			default: wmask = 4'h0;
		endcase
		case (funct3)
			3'b001:  csr_wdata = src1;            // csrrw
			3'b010:  csr_wdata = src1 | csr_val;  // csrrs
			default: csr_wdata = 32'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/exec_stage.sv
`timescale 1ns/100ps
`default_nettype none

module exec_stage #(
	parameter logic [31:0] RESET_PC = 32'h0000_0100
) (
	input  logic  clk,
	input  logic  rst,
	issue_if.dst  iss,
	commit_if.src cmt
);

	exec_pkg::decoded_t d;
	exec_pkg::commit_t  rec;
	logic               fire;
	logic [31:0]        pc;
	logic [31:0]        next_pc;
	logic [31:0]        src1;
	logic [31:0]        src2;
	logic [31:0]        csr_rdata;
	logic [31:0]        csr_wdata;
	logic [31:0]        val;
	logic [31:0]        jump;
	logic [3:0]         wmask;
	logic               is_sys;
	logic               is_store;
	logic               rd_we;
	logic [31:0]        rd_wdata;

	assign d = iss.dec;
	assign fire = iss.valid & ~cmt.full;  // take and load together
	assign iss.take = fire;
	assign cmt.load = fire;

	assign is_sys = (d.opcode == exec_pkg::OPC_SYSTEM);
	assign is_store = (d.opcode == exec_pkg::OPC_STORE);
	assign rd_we = (d.rd != 5'd0) & ((d.fmt == exec_pkg::FMT_U) | (d.fmt == exec_pkg::FMT_J) |
		(d.opcode == exec_pkg::OPC_JALR) | (d.opcode == exec_pkg::OPC_OP) |
		(d.opcode == exec_pkg::OPC_OPIMM) | is_sys);
	assign rd_wdata = is_sys ? csr_rdata : val;  // csr ops return the old value
	assign next_pc = (jump != 32'b0) ? jump : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= RESET_PC;
		else if (fire)
			pc <= next_pc;
	end

	reg_file u_regs (
		.clk       (clk),
		.rst       (rst),
		.rs1       (d.rs1),
		.rs2       (d.rs2),
		.rs1_data  (src1),
		.rs2_data  (src2),
		.rd        (d.rd),
		.rd_we     (fire & rd_we),
		.rd_wdata  (rd_wdata),
		.csr_addr  (d.csr_addr),
		.csr_rdata (csr_rdata),
		.csr_we    (fire & is_sys & (d.funct3 == 3'b001 || d.funct3 == 3'b010)),
		.csr_wdata (csr_wdata)
	);

	exu u_exu (
		.opcode    (d.opcode),
		.src1      (src1),
		.src2      (src2),
		.imm       (d.imm),
		.fmt       (d.fmt),
		.funct3    (d.funct3),
		.funct7    (d.funct7),
		.pc        (pc),
		.csr_val   (csr_rdata),
		.val       (val),
		.jump      (jump),
		.csr_wdata (csr_wdata),
		.wmask     (wmask)
	);

	always_comb begin
		rec.pc = pc;
		rec.next_pc = next_pc;
		rec.rd = rd_we ? d.rd : 5'd0;
		rec.rd_wdata = rd_we ? rd_wdata : 32'b0;
		rec.rd_we = rd_we;
		rec.is_store = is_store;
		rec.st_addr = is_store ? src1 + d.imm : 32'b0;
		rec.st_data = is_store ? src2 : 32'b0;
		rec.st_mask = is_store ? wmask : 4'h0;
	end

	assign cmt.rec = rec;

endmodule

`default_nettype wire

// File: source/commit_port.sv
`timescale 1ns/100ps
`default_nettype none

module commit_port (
	input  logic        clk,
	input  logic        rst,
	commit_if.dst       cmt,
	output logic        out_req,
	input  logic        out_ack,
	output logic [31:0] out_pc,
	output logic [31:0] out_next_pc,
	output logic [4:0]  out_rd,
	output logic [31:0] out_rd_wdata,
	output logic        out_rd_we,
	output logic        out_is_store,
	output logic [31:0] out_st_addr,
	output logic [31:0] out_st_data,
	output logic [3:0]  out_st_mask
);

	typedef enum logic [1:0] {TX_IDLE, TX_REQ, TX_DONE} tx_state_t;

	tx_state_t         tx_state;
	exec_pkg::commit_t rec_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_state <= TX_IDLE;
		end else begin
			case (tx_state)
				TX_IDLE: if (cmt.load) tx_state <= TX_REQ;
				TX_REQ:  if (out_ack) tx_state <= TX_DONE;   // drop req
				TX_DONE: if (!out_ack) tx_state <= TX_IDLE;  // slot free
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmt.load)
			rec_q <= cmt.rec;
	end

	assign cmt.full = (tx_state != TX_IDLE);
	assign out_req = (tx_state == TX_REQ);

	assign out_pc = rec_q.pc;
	assign out_next_pc = rec_q.next_pc;
	assign out_rd = rec_q.rd;
	assign out_rd_wdata = rec_q.rd_wdata;
	assign out_rd_we = rec_q.rd_we;
	assign out_is_store = rec_q.is_store;
	assign out_st_addr = rec_q.st_addr;
	assign out_st_data = rec_q.st_data;
	assign out_st_mask = rec_q.st_mask;

endmodule

`default_nettype wire

// File: source/exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module exec_top #(
	parameter logic [31:0] RESET_PC = 32'h0000_0100
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_req,
	output logic        in_ack,
	input  logic [31:0] in_insn,
	output logic        out_req,
	input  logic        out_ack,
	output logic [31:0] out_pc,
	output logic [31:0] out_next_pc,
	output logic [4:0]  out_rd,
	output logic [31:0] out_rd_wdata,
	output logic        out_rd_we,
	output logic        out_is_store,
	output logic [31:0] out_st_addr,
	output logic [31:0] out_st_data,
	output logic [3:0]  out_st_mask
);

	issue_if  iss_bus ();
	commit_if cmt_bus ();

	insn_accept u_accept (
		.clk     (clk),
		.rst     (rst),
		.in_req  (in_req),
		.in_ack  (in_ack),
		.in_insn (in_insn),
		.iss     (iss_bus.src)
	);

	exec_stage #(
		.RESET_PC (RESET_PC)
	) u_stage (
		.clk (clk),
		.rst (rst),
		.iss (iss_bus.dst),
		.cmt (cmt_bus.src)
	);

	commit_port u_commit (
		.clk          (clk),
		.rst          (rst),
		.cmt          (cmt_bus.dst),
		.out_req      (out_req),
		.out_ack      (out_ack),
		.out_pc       (out_pc),
		.out_next_pc  (out_next_pc),
		.out_rd       (out_rd),
		.out_rd_wdata (out_rd_wdata),
		.out_rd_we    (out_rd_we),
		.out_is_store (out_is_store),
		.out_st_addr  (out_st_addr),
		.out_st_data  (out_st_data),
		.out_st_mask  (out_st_mask)
	);

endmodule

`default_nettype wire

// File: dv/exec_vectors.svh
// columns: name, insn, next_pc, rd, rd_we, rd_wdata, is_store, st_addr, st_data, st_mask
// rows run in program order from pc 0x100 and build on register values set by earlier rows
task automatic build_table();
	// operand setup
	add_row("addi x1", enc_opi(-5, 0, 0, 1), 32'h104, 1, 1, 32'hfffffffb, 0, 0, 0, 0);
	add_row("addi x2", enc_opi(3, 0, 0, 2), 32'h108, 2, 1, 32'h3, 0, 0, 0, 0);
	add_row("lui x3", enc_u(32'h12345, 3, exec_pkg::OPC_LUI), 32'h10c, 3, 1, 32'h12345000,
		0, 0, 0, 0);
	add_row("auipc x4", enc_u(1, 4, exec_pkg::OPC_AUIPC), 32'h110, 4, 1, 32'h110c, 0, 0, 0, 0);

	// register-register ops
	add_row("add", enc_r(0, 2, 1, 0, 5), 32'h114, 5, 1, 32'hfffffffe, 0, 0, 0, 0);
	add_row("sub", enc_r(32, 1, 2, 0, 6), 32'h118, 6, 1, 32'h8, 0, 0, 0, 0);
	add_row("and", enc_r(0, 3, 1, 7, 7), 32'h11c, 7, 1, 32'h12345000, 0, 0, 0, 0);
	add_row("or", enc_r(0, 3, 2, 6, 8), 32'h120, 8, 1, 32'h12345003, 0, 0, 0, 0);
	add_row("xor", enc_r(0, 3, 1, 4, 9), 32'h124, 9, 1, 32'hedcbaffb, 0, 0, 0, 0);
	add_row("slt", enc_r(0, 2, 1, 2, 10), 32'h128, 10, 1, 32'h1, 0, 0, 0, 0);
	add_row("sltu", enc_r(0, 2, 1, 3, 11), 32'h12c, 11, 1, 32'h0, 0, 0, 0, 0);
	add_row("addi x12", enc_opi(35, 0, 0, 12), 32'h130, 12, 1, 32'h23, 0, 0, 0, 0);
	add_row("sll", enc_r(0, 12, 2, 1, 13), 32'h134, 13, 1, 32'h18, 0, 0, 0, 0);  // 35 -> 3
	add_row("srl", enc_r(0, 12, 1, 5, 14), 32'h138, 14, 1, 32'h1fffffff, 0, 0, 0, 0);
	add_row("sra", enc_r(32, 12, 1, 5, 15), 32'h13c, 15, 1, 32'hffffffff, 0, 0, 0, 0);

	// branches, x1 = -5, x2 = 3
	add_row("beq taken", enc_b(8, 2, 2, 0), 32'h144, 0, 0, 0, 0, 0, 0, 0);
	add_row("bne not taken", enc_b(8, 2, 2, 1), 32'h148, 0, 0, 0, 0, 0, 0, 0);
	add_row("blt taken", enc_b(12, 2, 1, 4), 32'h154, 0, 0, 0, 0, 0, 0, 0);
	add_row("bge not taken", enc_b(8, 2, 1, 5), 32'h158, 0, 0, 0, 0, 0, 0, 0);
	add_row("bltu not taken", enc_b(8, 2, 1, 6), 32'h15c, 0, 0, 0, 0, 0, 0, 0);
	add_row("bgeu taken back", enc_b(-16, 2, 1, 7), 32'h14c, 0, 0, 0, 0, 0, 0, 0);

	// jumps
	add_row("jal", enc_j(64, 16), 32'h18c, 16, 1, 32'h150, 0, 0, 0, 0);
	add_row("addi x17", enc_opi(512, 0, 0, 17), 32'h190, 17, 1, 32'h200, 0, 0, 0, 0);
	add_row("jalr", enc_i(16, 17, 0, 18, exec_pkg::OPC_JALR), 32'h210, 18, 1, 32'h194,
		0, 0, 0, 0);

	// stores
	add_row("sb", enc_s(4, 9, 17, 0), 32'h214, 0, 0, 0, 1, 32'h204, 32'hedcbaffb, 4'h1);
	add_row("sh", enc_s(-2, 8, 17, 1), 32'h218, 0, 0, 0, 1, 32'h1fe, 32'h12345003, 4'h3);
	add_row("sw", enc_s(0, 5, 3, 2), 32'h21c, 0, 0, 0, 1, 32'h12345000, 32'hfffffffe, 4'hf);
	add_row("addi x0", enc_opi(7, 2, 0, 0), 32'h220, 0, 0, 0, 0, 0, 0, 0);
	add_row("sw x0", enc_s(8, 0, 17, 2), 32'h224, 0, 0, 0, 1, 32'h208, 32'h0, 4'hf);

	// mtvec swap then set bits
	add_row("csrrw mtvec", enc_csr(exec_pkg::CSR_MTVEC, 8, 1, 20), 32'h228, 20, 1, 32'h0,
		0, 0, 0, 0);
	add_row("csrrs mtvec", enc_csr(exec_pkg::CSR_MTVEC, 6, 2, 21), 32'h22c, 21, 1,
		32'h12345003, 0, 0, 0, 0);
	add_row("csrrs readback", enc_csr(exec_pkg::CSR_MTVEC, 0, 2, 22), 32'h230, 22, 1,
		32'h1234500b, 0, 0, 0, 0);
	add_row("srai", enc_opi(1025, 1, 5, 23), 32'h234, 23, 1, 32'hfffffffd, 0, 0, 0, 0);
endtask

// File: dv/exec_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exec_tb;

	localparam int          MAX_ROWS = 64;
	localparam int          TIMEOUT = 100;  // cycles per wait
	localparam logic [31:0] START_PC = 32'h0000_0100;

	logic        clk;
	logic        rst;
	logic        in_req;
	logic        in_ack;
	logic [31:0] in_insn;
	logic        out_req;
	logic        out_ack;
	logic [31:0] out_pc;
	logic [31:0] out_next_pc;
	logic [4:0]  out_rd;
	logic [31:0] out_rd_wdata;
	logic        out_rd_we;
	logic        out_is_store;
	logic [31:0] out_st_addr;
	logic [31:0] out_st_data;
	logic [3:0]  out_st_mask;

	string       row_name [0:MAX_ROWS-1];
	logic [31:0] row_insn [0:MAX_ROWS-1];
	logic [31:0] row_next_pc [0:MAX_ROWS-1];
	logic [4:0]  row_rd [0:MAX_ROWS-1];
	logic        row_rd_we [0:MAX_ROWS-1];
	logic [31:0] row_rd_wdata [0:MAX_ROWS-1];
	logic        row_is_store [0:MAX_ROWS-1];
	logic [31:0] row_st_addr [0:MAX_ROWS-1];
	logic [31:0] row_st_data [0:MAX_ROWS-1];
	logic [3:0]  row_st_mask [0:MAX_ROWS-1];
	int          n_rows;

	exec_top UUT (
		.clk          (clk),
		.rst          (rst),
		.in_req       (in_req),
		.in_ack       (in_ack),
		.in_insn      (in_insn),
		.out_req      (out_req),
		.out_ack      (out_ack),
		.out_pc       (out_pc),
		.out_next_pc  (out_next_pc),
		.out_rd       (out_rd),
		.out_rd_wdata (out_rd_wdata),
		.out_rd_we    (out_rd_we),
		.out_is_store (out_is_store),
		.out_st_addr  (out_st_addr),
		.out_st_data  (out_st_data),
		.out_st_mask  (out_st_mask)
	);

	// rv32i encoders
	function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
			input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], exec_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
			input int rd, input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] enc_opi(input int imm, input int rs1, input int f3,
			input int rd);
		return enc_i(imm, rs1, f3, rd, exec_pkg::OPC_OPIMM);
	endfunction

	function automatic logic [31:0] enc_csr(input int csr, input int rs1, input int f3,
			input int rd);
		return enc_i(csr, rs1, f3, rd, exec_pkg::OPC_SYSTEM);
	endfunction

	function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] opc);
		return {imm[19:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
			input int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], exec_pkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input int off, input int rs2, input int rs1,
			input int f3);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
			exec_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input int off, input int rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], exec_pkg::OPC_JAL};
	endfunction

	task automatic add_row(input string name, input logic [31:0] insn,
			input logic [31:0] next_pc, input logic [4:0] rd, input logic rd_we,
			input logic [31:0] rd_wdata, input logic is_store, input logic [31:0] st_addr,
			input logic [31:0] st_data, input logic [3:0] st_mask);
		row_name[n_rows] = name;
		row_insn[n_rows] = insn;
		row_next_pc[n_rows] = next_pc;
		row_rd[n_rows] = rd;
		row_rd_we[n_rows] = rd_we;
		row_rd_wdata[n_rows] = rd_wdata;
		row_is_store[n_rows] = is_store;
		row_st_addr[n_rows] = st_addr;
		row_st_data[n_rows] = st_data;
		row_st_mask[n_rows] = st_mask;
		n_rows++;
	endtask

	`include "exec_vectors.svh"

	task automatic compare(input string name, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s expected %h actual %h", name, field, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on timeout");
	endtask

	// four-phase send of one word, driven on the falling edge
	task automatic send_insn(input logic [31:0] word);
		int cycles;
		@(negedge clk);
		in_insn = word;
		in_req = 1'b1;
		cycles = 0;
		while (!in_ack) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				timeout_fail("in_ack to rise");
		end
		in_req = 1'b0;
		cycles = 0;
		while (in_ack) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				timeout_fail("in_ack to fall");
		end
	endtask

	task automatic send_all();
		int row;
		for (row = 0; row < n_rows; row++)
			send_insn(row_insn[row]);
	endtask

	task automatic receive_all();
		int          row;
		int          cycles;
		int          delay;
		logic [31:0] exp_pc;
		exp_pc = START_PC;
		for (row = 0; row < n_rows; row++) begin
			cycles = 0;
			while (!out_req) begin
				@(negedge clk);
				cycles++;
				if (cycles > TIMEOUT)
					timeout_fail($sformatf("commit record of row %0d", row));
			end
			delay = $urandom % 6;  // back-pressure
			repeat (delay) @(negedge clk);
			compare(row_name[row], "pc", exp_pc, out_pc);
			compare(row_name[row], "next_pc", row_next_pc[row], out_next_pc);
			compare(row_name[row], "rd", row_rd[row], out_rd);
			compare(row_name[row], "rd_we", row_rd_we[row], out_rd_we);
			compare(row_name[row], "rd_wdata", row_rd_wdata[row], out_rd_wdata);
			compare(row_name[row], "is_store", row_is_store[row], out_is_store);
			compare(row_name[row], "st_addr", row_st_addr[row], out_st_addr);
			compare(row_name[row], "st_data", row_st_data[row], out_st_data);
			compare(row_name[row], "st_mask", row_st_mask[row], out_st_mask);
			out_ack = 1'b1;
			cycles = 0;
			while (out_req) begin
				@(negedge clk);
				cycles++;
				if (cycles > TIMEOUT)
					timeout_fail("out_req to fall");
			end
			out_ack = 1'b0;
			exp_pc = row_next_pc[row];  // program order
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		in_req = 1'b0;
		in_insn = 32'b0;
		out_ack = 1'b0;
		n_rows = 0;
		void'($urandom(32'hb3ba1feb));
		build_table();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		fork
			send_all();
			receive_all();
		join
		// nothing extra may come out
		repeat (20) begin
			@(negedge clk);
			compare("tail", "out_req", 32'd0, {31'd0, out_req});
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+dv
source/exec_pkg.sv
source/exec_if.sv
source/insn_accept.sv
source/reg_file.sv
source/exu.sv
source/exec_stage.sv
source/commit_port.sv
source/exec_top.sv
dv/exec_tb.sv
